// File: hdl/uart_config.svh
`ifndef UART_CONFIG_SVH
`define UART_CONFIG_SVH

// system clock in Hz
`define UART_CLK_HZ 125000000

// 16 clocks per bit at the default clock
`define DEFAULT_BAUD 7812500

// clocks per bit for a given baud rounded down to even
`define UART_BAUD_CLKS(baud) ((`UART_CLK_HZ / (baud)) / 2 * 2)

`define UART_CLK_PER_BIT `UART_BAUD_CLKS(`DEFAULT_BAUD)

// number of receive FIFO entries (power of two)
`define UART_FIFO_DEPTH 4

`endif

// File: hdl/uart_pkg.sv
`default_nettype none

package uart_pkg;

    // ********************
    // received frame
    // ********************

    typedef struct packed {
        logic       ferr;   // stop bit sampled low
        logic [7:0] data;
    } rx_byte_t;

    // ********************
    // receiver FSM
    // ********************

    typedef enum logic [1:0] {
        s_idle  = 2'd0,     // waiting for falling edge
        s_start = 2'd1,     // half-bit start check
        s_data  = 2'd2,
        s_stop  = 2'd3
    } rx_state_e;

endpackage

`default_nettype wire

// File: hdl/uart_tx.sv
`include "uart_config.svh"

`default_nettype none

module uart_tx #(
    parameter int BAUD = `DEFAULT_BAUD
) (
    input  logic       clk,
    input  logic       rstn,
    input  logic       order,
    input  logic [7:0] write_data,
    output logic       sendable,
    output logic       txd
);

    localparam int CLK_PER_BIT = `UART_BAUD_CLKS(BAUD);
    localparam int STOP_CLKS   = CLK_PER_BIT * 9 / 10;  // stop bit held 90 %
    localparam int CNT_W       = $clog2(CLK_PER_BIT);

    localparam logic [3:0] s_idle  = 4'd0;
    localparam logic [3:0] s_start = 4'd1;
    localparam logic [3:0] s_bit7  = 4'd9;      // bits 0..6 are 2..8
    localparam logic [3:0] s_stop  = 4'd10;

    logic [CNT_W-1:0] bit_cnt;
    logic             bit_tick;
    logic             stop_tick;
    logic             ready_q;
    logic             accept;
    logic [3:0]       state;
    logic [7:0]       shift_q;
    logic             shift_en;

    assign accept   = order & ready_q;
    assign sendable = ready_q & ~order;         // drops in the order cycle

    // ********************
    // bit timing
    // ********************

    always_ff @(posedge clk) begin
        if (!rstn) begin
            bit_cnt <= '0;
        end else if (accept || bit_tick) begin
            bit_cnt <= '0;                      // restart on a new frame
        end else begin
            bit_cnt <= bit_cnt + 1'b1;
        end
    end

    assign bit_tick  = (bit_cnt == CNT_W'(CLK_PER_BIT - 1));
    assign stop_tick = (bit_cnt == CNT_W'(STOP_CLKS - 1));

    // ********************
    // frame FSM
    // ********************

    always_ff @(posedge clk) begin
        if (!rstn) begin
            state   <= s_idle;
            ready_q <= 1'b1;
            txd     <= 1'b1;
        end else begin
            case (state)
                s_idle: begin
                    if (accept) begin
                        state   <= s_start;
                        ready_q <= 1'b0;
                        txd     <= 1'b0;        // start bit
                    end
                end
                s_stop: begin
                    if (stop_tick) begin
                        state   <= s_idle;
                        ready_q <= 1'b1;
                    end
                end
                default: begin
                    if (bit_tick) begin
                        if (state == s_bit7) begin
                            state <= s_stop;
                            txd   <= 1'b1;
                        end else begin
                            state <= state + 1'b1;
                            txd   <= shift_q[0];    // LSB first
                        end
                    end
                end
            endcase
        end
    end

    assign shift_en = bit_tick && (state != s_idle) && (state != s_stop);

    always_ff @(posedge clk) begin
        if (accept) begin
            shift_q <= write_data;
        end else if (shift_en) begin
            shift_q <= {1'b1, shift_q[7:1]};
        end
    end

endmodule

`default_nettype wire

// File: hdl/uart_rx.sv
`include "uart_config.svh"

`default_nettype none

module uart_rx #(
    parameter int BAUD = `DEFAULT_BAUD
) (
    input  logic               clk,
    input  logic               rstn,
    input  logic               rxd,
    output logic               push,
    output uart_pkg::rx_byte_t rx_word
);

    import uart_pkg::*;

    localparam int CLK_PER_BIT = `UART_BAUD_CLKS(BAUD);
    localparam int HALF_BIT    = CLK_PER_BIT / 2;
    localparam int CNT_W       = $clog2(CLK_PER_BIT);

    logic             rxd_meta;
    logic             rxd_sync;
    logic             rxd_prev;
    logic             fall;
    rx_state_e        state;
    logic [CNT_W-1:0] cnt;
    logic [2:0]       bit_idx;
    logic [7:0]       shift_q;
    logic             half_done;
    logic             bit_done;

    // ********************
    // input synchronizer
    // ********************

    always_ff @(posedge clk) begin
        if (!rstn) begin
            rxd_meta <= 1'b1;               // line idles high
            rxd_sync <= 1'b1;
            rxd_prev <= 1'b1;
        end else begin
            rxd_meta <= rxd;
            rxd_sync <= rxd_meta;
            rxd_prev <= rxd_sync;
        end
    end

    assign fall      = rxd_prev & ~rxd_sync;
    assign half_done = (cnt == CNT_W'(HALF_BIT - 1));
    assign bit_done  = (cnt == CNT_W'(CLK_PER_BIT - 1));

    // ********************
    // receive FSM
    // ********************

    always_ff @(posedge clk) begin
        if (!rstn) begin
            state   <= s_idle;
            cnt     <= '0;
            bit_idx <= '0;
            push    <= 1'b0;
        end else begin
            push <= 1'b0;
            case (state)
                s_idle: begin
                    cnt <= '0;
                    if (fall) begin
                        state <= s_start;
                    end
                end
                s_start: begin
                    if (half_done) begin
                        cnt     <= '0;
                        bit_idx <= '0;
                        // still low at mid-bit, else a glitch
                        state   <= rxd_sync ? s_idle : s_data;
                    end else begin
                        cnt <= cnt + 1'b1;
                    end
                end
                s_data: begin
                    if (bit_done) begin
                        cnt     <= '0;
                        bit_idx <= bit_idx + 1'b1;
                        if (bit_idx == 3'd7) begin
                            state <= s_stop;
                        end
                    end else begin
                        cnt <= cnt + 1'b1;
                    end
                end
                s_stop: begin
                    if (bit_done) begin
                        push  <= 1'b1;      // pushed even with a bad stop bit
                        state <= s_idle;
                    end else begin
                        cnt <= cnt + 1'b1;
                    end
                end
                default: state <= s_idle;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (state == s_data && bit_done) begin
            shift_q <= {rxd_sync, shift_q[7:1]};   // LSB arrives first
        end
        if (state == s_stop && bit_done) begin
            rx_word.data <= shift_q;
            rx_word.ferr <= ~rxd_sync;
        end
    end

endmodule

`default_nettype wire

// File: hdl/uart_rx_fifo.sv
`include "uart_config.svh"

`default_nettype none

module uart_rx_fifo #(
    parameter int DEPTH = `UART_FIFO_DEPTH
) (
    input  logic               clk,
    input  logic               rstn,
    input  logic               push,
    input  uart_pkg::rx_byte_t push_word,
    input  logic               pop,
    output uart_pkg::rx_byte_t head_word,
    output logic               not_empty,
    output logic               overrun
);

    import uart_pkg::*;

    localparam int AW = $clog2(DEPTH);

    rx_byte_t      mem [DEPTH];
    logic [AW:0]   wr_ptr;                  // extra bit tells full from empty
    logic [AW:0]   rd_ptr;
    logic          full;
    logic          do_push;
    logic          do_pop;

    assign not_empty = (wr_ptr != rd_ptr);
    assign full      = (wr_ptr[AW] != rd_ptr[AW]) &&
                       (wr_ptr[AW-1:0] == rd_ptr[AW-1:0]);

    assign do_pop  = pop & not_empty;
    assign do_push = push & (~full | do_pop);   // full + pop frees a slot

    assign head_word = mem[rd_ptr[AW-1:0]];

    // ********************
    // pointers and flags
    // ********************

    always_ff @(posedge clk) begin
        if (!rstn) begin
            wr_ptr  <= '0;
            rd_ptr  <= '0;
            overrun <= 1'b0;
        end else begin
            if (do_push) begin
                wr_ptr <= wr_ptr + 1'b1;
            end
            if (do_pop) begin
                rd_ptr <= rd_ptr + 1'b1;
            end
            if (push && !do_push) begin
                overrun <= 1'b1;            // sticky until reset
            end
        end
    end

    // storage
    always_ff @(posedge clk) begin
        if (do_push) begin
            mem[wr_ptr[AW-1:0]] <= push_word;
        end
    end

endmodule

`default_nettype wire

// File: hdl/uart_top.sv
`default_nettype none

module uart_top (
    input  logic               clk,
    input  logic               rstn,

    // transmit side
    input  logic               order,
    input  logic [7:0]         write_data,
    output logic               sendable,
    output logic               txd,

    // receive side
    input  logic               rxd,
    input  logic               rx_read,
    output logic               rx_valid,
    output uart_pkg::rx_byte_t rx_data,
    output logic               overrun
);

    import uart_pkg::*;

    rx_byte_t rx_word;
    logic     rx_push;

    uart_tx i_tx (
        .clk        (clk),
        .rstn       (rstn),
        .order      (order),
        .write_data (write_data),
        .sendable   (sendable),
        .txd        (txd)
    );

    uart_rx i_rx (
        .clk     (clk),
        .rstn    (rstn),
        .rxd     (rxd),
        .push    (rx_push),
        .rx_word (rx_word)
    );

    // bytes wait here for the reader
    uart_rx_fifo i_rx_fifo (
        .clk       (clk),
        .rstn      (rstn),
        .push      (rx_push),
        .push_word (rx_word),
        .pop       (rx_read),
        .head_word (rx_data),
        .not_empty (rx_valid),
        .overrun   (overrun)
    );

endmodule

`default_nettype wire

// File: tests/tb_uart_checks.sv
`include "uart_config.svh"

`default_nettype none

module tb_uart_checks (
    input logic                clk,
    input logic                rstn,
    input logic                order,
    input logic [7:0]          write_data,
    input logic                sendable,
    input logic                txd,
    input logic                rx_read,
    input logic                rx_valid,
    input uart_pkg::rx_byte_t  rx_data,
    input logic                overrun,
    input logic                exp_avail,
    input uart_pkg::rx_byte_t  exp_word,
    input logic                glitch_window,
    input uart_pkg::rx_state_e rx_state
);

    timeunit 1ns;
    timeprecision 100ps;

    import uart_pkg::*;

    localparam int CPB       = `UART_CLK_PER_BIT;
    localparam int FRAME_CYC = 9 * CPB + CPB * 9 / 10;     // order to next sendable

    int         value_errs = 0;
    int         proto_errs = 0;
    logic       busy;
    int         frame_cyc;
    int         bit_no;
    logic [7:0] frame_data;
    logic       exp_txd;
    logic       seen_order = 1'b0;

    // ********************
    // transmit frame model
    // ********************

    always @(posedge clk) begin
        if (!rstn) begin
            busy      <= 1'b0;
            frame_cyc <= 0;
        end else if (!busy) begin
            if (order) begin
                busy       <= 1'b1;                // orders while busy are dropped
                frame_cyc  <= 0;
                frame_data <= write_data;
            end
        end else if (frame_cyc == FRAME_CYC - 1) begin
            busy <= 1'b0;
        end else begin
            frame_cyc <= frame_cyc + 1;
        end
    end

    always @(posedge clk) begin
        if (rstn && order) begin
            seen_order <= 1'b1;
        end
    end

    always_comb begin
        bit_no = frame_cyc / CPB;
        if (!busy || bit_no > 8) begin
            exp_txd = 1'b1;                        // idle or stop
        end else if (bit_no == 0) begin
            exp_txd = 1'b0;                        // start bit
        end else begin
            exp_txd = frame_data[3'(bit_no - 1)];
        end
    end

    // ********************
    // transmit side
    // ********************

    tx_line: assert property (@(posedge clk) disable iff (!rstn) txd == exp_txd)
        else begin
            value_errs++;
            $display("[ERROR] txd: got %h, expected %h", $sampled(txd), $sampled(exp_txd));
        end

    tx_ready: assert property (@(posedge clk) disable iff (!rstn)
                               sendable == (!busy && !order))
        else begin
            value_errs++;
            $display("[ERROR] sendable: got %h, expected %h", $sampled(sendable),
                     $sampled(!busy && !order));
        end

    // ********************
    // receive side
    // ********************

    rx_quiet: assert property (@(posedge clk) disable iff (!rstn)
                               !seen_order |-> !rx_valid && !overrun)
        else begin
            proto_errs++;
            $display("receive side became active before the first order");
        end

    overrun_sticky: assert property (@(posedge clk) disable iff (!rstn) overrun |=> overrun)
        else begin
            value_errs++;
            $display("[ERROR] overrun: got %h, expected %h", $sampled(overrun), 1'b1);
        end

    read_known: assert property (@(posedge clk) disable iff (!rstn)
                                 rx_read && rx_valid |-> exp_avail)
        else begin
            proto_errs++;
            $display("a byte was read while none was expected");
        end

    read_data: assert property (@(posedge clk) disable iff (!rstn)
                                rx_read && rx_valid && exp_avail |-> rx_data == exp_word)
        else begin
            value_errs++;
            $display("[ERROR] rx_data: got %h, expected %h", $sampled(rx_data),
                     $sampled(exp_word));
        end

    glitch_reject: assert property (@(posedge clk) disable iff (!rstn)
                                    glitch_window |-> rx_state != s_data)
        else begin
            proto_errs++;
            $display("receiver took a short low pulse for a start bit, state %s",
                     rx_state.name());
        end

endmodule

`default_nettype wire

// File: tests/tb_uart.sv
`include "uart_config.svh"

`default_nettype none

module tb_uart #(
    parameter int SEED = 32'h356a_49aa
);

    timeunit 1ns;
    timeprecision 100ps;

    import uart_pkg::*;

    localparam int     CPB         = `UART_CLK_PER_BIT;
    localparam int     DEPTH       = `UART_FIFO_DEPTH;
    localparam int     N_LOOP      = 20;
    localparam int     N_BYTES     = 2 + N_LOOP + DEPTH + 2 + 2;
    localparam longint WATCHDOG_NS = longint'(N_BYTES + 8) * 11 * CPB * 8;

    logic       clk;
    logic       rstn;
    logic       order;
    logic [7:0] write_data;
    logic       sendable;
    logic       txd;
    logic       rxd;
    logic       rx_read;
    logic       rx_valid;
    rx_byte_t   rx_data;
    logic       overrun;

    logic       loopback;
    logic       line;
    logic       glitch_window;
    logic       exp_avail;
    rx_byte_t   exp_word;
    rx_byte_t   exp_q [$];
    int         seed = SEED;
    int         seq_errs = 0;

    assign rxd = loopback ? txd : line;         // serial line mux

    always #4 clk = ~clk;

    uart_top i_dut (
        .clk        (clk),
        .rstn       (rstn),
        .order      (order),
        .write_data (write_data),
        .sendable   (sendable),
        .txd        (txd),
        .rxd        (rxd),
        .rx_read    (rx_read),
        .rx_valid   (rx_valid),
        .rx_data    (rx_data),
        .overrun    (overrun)
    );

    tb_uart_checks i_checks (
        .clk           (clk),
        .rstn          (rstn),
        .order         (order),
        .write_data    (write_data),
        .sendable      (sendable),
        .txd           (txd),
        .rx_read       (rx_read),
        .rx_valid      (rx_valid),
        .rx_data       (rx_data),
        .overrun       (overrun),
        .exp_avail     (exp_avail),
        .exp_word      (exp_word),
        .glitch_window (glitch_window),
        .rx_state      (i_dut.i_rx.state)
    );

    // ********************
    // stimulus tasks
    // ********************

    task automatic step();
        @(posedge clk);
        #1;
    endtask

    task automatic report_mismatch(input string name, input logic [31:0] got,
                                   input logic [31:0] exp);
        seq_errs++;
        $display("[ERROR] %s: got %h, expected %h", name, got, exp);
    endtask

    task automatic expect_word(input logic [7:0] data, input logic ferr);
        rx_byte_t w;
        w.data = data;
        w.ferr = ferr;
        exp_q.push_back(w);
    endtask

    task automatic send_byte(input logic [7:0] data, input bit expect_rx);
        if (expect_rx) begin
            expect_word(data, 1'b0);
        end
        order      = 1'b1;
        write_data = data;
        step();
        order = 1'b0;
    endtask

    task automatic wait_sendable();
        while (!sendable) begin
            step();
        end
    endtask

    task automatic read_entry();
        exp_avail = (exp_q.size() != 0);
        exp_word  = exp_avail ? exp_q[0] : '0;
        rx_read   = 1'b1;
        step();
        rx_read = 1'b0;
        if (exp_avail) begin
            void'(exp_q.pop_front());
        end
    endtask

    task automatic read_entries(input int n);
        int got;
        got = 0;
        while (got < n) begin
            if (rx_valid) begin
                read_entry();
                got++;
            end else begin
                step();
            end
        end
    endtask

    // start, data LSB first, stop, then two idle bits
    task automatic drive_frame(input logic [7:0] data, input logic stop_bit);
        logic [9:0] bits;
        bits = {stop_bit, data, 1'b0};
        for (int i = 0; i < 10; i++) begin
            line = bits[0];
            bits = bits >> 1;
            repeat (CPB) step();
        end
        line = 1'b1;
        repeat (2 * CPB) step();
    endtask

    // ********************
    // test sequence
    // ********************

    initial begin
        logic [7:0] b;
        int         total;
        clk           = 1'b0;
        rstn          = 1'b0;
        order         = 1'b0;
        write_data    = '0;
        rx_read       = 1'b0;
        loopback      = 1'b1;
        line          = 1'b1;
        glitch_window = 1'b0;
        exp_avail     = 1'b0;
        exp_word      = '0;
        repeat (3) @(posedge clk);
        #1;
        rstn = 1'b1;
        repeat (4 * CPB) step();                // quiet line after reset

        // one frame and an order while busy
        send_byte(8'($random(seed)), 1'b1);
        repeat (CPB + 3) step();
        send_byte(8'($random(seed)), 1'b0);
        wait_sendable();
        read_entries(1);

        // back to back loopback bytes
        fork
            begin
                for (int i = 0; i < N_LOOP; i++) begin
                    wait_sendable();
                    send_byte(8'($random(seed)), 1'b1);
                end
            end
            read_entries(N_LOOP);
        join

        // fill past the FIFO depth without reading
        for (int i = 1; i <= DEPTH + 2; i++) begin
            wait_sendable();
            send_byte(8'($random(seed)), i <= DEPTH);
            wait_sendable();
            repeat (2) step();
            overrun_seen: assert (overrun == (i > DEPTH))
                else report_mismatch("overrun", 32'(overrun), 32'(i > DEPTH));
        end
        read_entries(DEPTH);
        repeat (2) step();
        fifo_drained: assert (!rx_valid)
            else report_mismatch("rx_valid", 32'(rx_valid), 32'd0);

        // bad stop bit then a good frame on the driven line
        loopback = 1'b0;
        b = 8'($random(seed));
        expect_word(b, 1'b1);
        drive_frame(b, 1'b0);
        b = 8'($random(seed));
        expect_word(b, 1'b0);
        drive_frame(b, 1'b1);
        read_entries(2);

        // short low pulse
        glitch_window = 1'b1;
        line          = 1'b0;
        repeat (CPB / 4 - 1) step();
        line = 1'b1;
        repeat (11 * CPB) begin                 // longer than a whole frame
            step();
            glitch_quiet: assert (!rx_valid)
                else report_mismatch("rx_valid", 32'(rx_valid), 32'd0);
        end
        glitch_window = 1'b0;

        repeat (4) step();
        total = seq_errs + i_checks.value_errs + i_checks.proto_errs;
        $display("errors: value %0d, protocol %0d, sequence %0d, total %0d",
                 i_checks.value_errs, i_checks.proto_errs, seq_errs, total);
        if (total == 0) begin
            $display("Test completed successfully");
        end else begin
            $display("Test failed");
        end
        $finish;
    end

    // watchdog
    initial begin
        #(WATCHDOG_NS);
        $display("simulation ran past %0d ns without finishing", WATCHDOG_NS);
        $display("Test failed");
        $finish;
    end

endmodule

`default_nettype wire

// File: verilog.f
+incdir+hdl
hdl/uart_pkg.sv
hdl/uart_tx.sv
hdl/uart_rx.sv
hdl/uart_rx_fifo.sv
hdl/uart_top.sv
tests/tb_uart_checks.sv
tests/tb_uart.sv

// File: Makefile
# Verilator simulation of the UART testbench

VERILATOR ?= verilator
TOP       ?= tb_uart
OBJ_DIR   ?= obj_dir
LOG       ?= sim.log
FILELIST  ?= verilog.f
# 32'h356a_49aa in decimal
SEED      ?= 896158122
TIMESCALE ?= 1ns/100ps
VFLAGS    ?= --binary --timing --assert -j 0

PASS_MSG  := Test completed successfully

.PHONY: sim clean

sim:
	$(VERILATOR) $(VFLAGS) --timescale $(TIMESCALE) --top-module $(TOP) \
		-GSEED=$(SEED) -Mdir $(OBJ_DIR) -f $(FILELIST)
	./$(OBJ_DIR)/V$(TOP) | tee $(LOG)
	@grep -q "$(PASS_MSG)" $(LOG)

clean:
	rm -rf $(OBJ_DIR) $(LOG)
